//--- build.f
+incdir+hw
hw/cplx_pkg.sv
hw/cplx_issue_if.sv
hw/inst_rom.sv
hw/cplx_data_ram.sv
hw/cplx_alu.sv
hw/cplx_seq.sv
hw/cplx_core.sv
testbench/cplx_core_properties.sv
testbench/tb_cplx_core.sv

//--- Bender.yml
package:
  name: cplx_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cplx_pkg.sv
      - hw/cplx_issue_if.sv
      - hw/inst_rom.sv
      - hw/cplx_data_ram.sv
      - hw/cplx_alu.sv
      - hw/cplx_seq.sv
      - hw/cplx_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/cplx_core_properties.sv
      - testbench/tb_cplx_core.sv

//--- testbench/tb_cplx_core.sv
`timescale 1ns/1ps
`include "cplx_config.svh"

module tb_cplx_core;
   import cplx_pkg::*;

   localparam int CLK_HALF       = 4;
   localparam int RESET_CYCLES   = 10;
   localparam int NUM_RUNS       = 3;
   localparam int CYCLES_PER_RUN = 200;
   localparam int NUM_OPS        = 5;
   localparam int NUM_OPERANDS   = 6;
   localparam int HOLD_CYCLES    = 60;
   localparam int QUIET_CYCLES   = 10;

   localparam logic [2:0] OPC_ADD  = 3'b001;
   localparam logic [2:0] OPC_SUB  = 3'b010;
   localparam logic [2:0] OPC_MULT = 3'b100;

   logic  clk;
   logic  arst_n;
   logic  load_en;
   addr_t load_addr;
   cplx_t load_data;
   logic  start;
   logic  busy;
   logic  done;
   logic  res_valid;
   addr_t res_addr;
   cplx_t res_data;
   logic  res_credit;

   int    seed;
   int    cycle;
   int    results_seen;
   int    credits_returned;
   logic  hold_credits;
   event  got_result;

   cplx_t mem_model [256];
   addr_t exp_addr_q [$];
   cplx_t exp_data_q [$];
   addr_t got_addr_q [$];
   cplx_t got_data_q [$];
   int    credit_due_q [$];

   cplx_core dut0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .load_en    (load_en),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .start      (start),
      .busy       (busy),
      .done       (done),
      .res_valid  (res_valid),
      .res_addr   (res_addr),
      .res_data   (res_data),
      .res_credit (res_credit)
   );

   always #(CLK_HALF) clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   //////////////////////////////////////////////////
   // Checking helpers
   //////////////////////////////////////////////////

   task automatic stop_with_failure();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         stop_with_failure();
      end
   endtask

   // Same words as the ROM
   function automatic inst_t program_word(input int idx);
      case (idx)
         0: return 32'h8001_0080;
         1: return 32'h8003_0281;
         2: return 32'h8005_0482;
         3: return 32'h2081_8083;
         4: return 32'h4083_8284;
         default: return 32'h0;
      endcase
   endfunction

   // Q8.8 complex arithmetic with wrap
   function automatic cplx_t ref_op(input logic [2:0] opc, input cplx_t a, input cplx_t b);
      logic signed [63:0] ar;
      logic signed [63:0] ai;
      logic signed [63:0] br;
      logic signed [63:0] bi;
      logic signed [63:0] re;
      logic signed [63:0] im;
      ar = $signed(a[31:16]);
      ai = $signed(a[15:0]);
      br = $signed(b[31:16]);
      bi = $signed(b[15:0]);
      re = 0;
      im = 0;
      if (opc == OPC_MULT) begin
         re = (ar * br - ai * bi) >>> 8;
         im = (ar * bi + ai * br) >>> 8;
      end else if (opc == OPC_ADD) begin
         re = ar + br;
         im = ai + bi;
      end else if (opc == OPC_SUB) begin
         re = ar - br;
         im = ai - bi;
      end
      return {re[15:0], im[15:0]};
   endfunction

   task automatic build_expected();
      inst_t w;
      addr_t s1;
      addr_t s2;
      addr_t d;
      for (int i = 0; i < NUM_OPS; i++) begin
         w  = program_word(i);
         d  = w[7:0];
         s1 = w[15:8];
         s2 = w[23:16];
         mem_model[d] = ref_op(w[31:29], mem_model[s1], mem_model[s2]);
         exp_addr_q.push_back(d);
         exp_data_q.push_back(mem_model[d]);
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic load_operands();
      for (int i = 0; i < NUM_OPERANDS; i++) begin
         @(negedge clk);
         load_en   = 1'b1;
         load_addr = addr_t'(i);
         load_data = $random(seed);
         mem_model[i] = load_data;
      end
      @(negedge clk);
      load_en = 1'b0;
   endtask

   task automatic run_program(input logic hold);
      int base;
      base = results_seen;
      check_value("busy", busy, 1'b0);
      build_expected();
      @(negedge clk);
      hold_credits = hold;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      if (hold) begin
         repeat (HOLD_CYCLES) @(negedge clk);
         // Sequencer starved in ISSUE
         check_value("results_while_held", results_seen - base, `RES_CREDITS);
         check_value("busy", busy, 1'b1);
         hold_credits = 1'b0;
      end
      while (!done) begin
         @(negedge clk);
      end
      check_value("results_at_done", results_seen - base, NUM_OPS);
      check_value("busy", busy, 1'b1);
      @(negedge clk);
      check_value("done", done, 1'b0);
      check_value("busy", busy, 1'b0);
      repeat (QUIET_CYCLES) begin
         @(negedge clk);
         check_value("res_valid", res_valid, 1'b0);
         check_value("done", done, 1'b0);
      end
      while (credit_due_q.size() != 0) begin
         @(negedge clk);
      end
      check_value("pending_results", exp_addr_q.size(), 0);
   endtask

   //////////////////////////////////////////////////
   // Consumer and compare
   //////////////////////////////////////////////////

   // Takes every result and returns its credit 0 to 7 cycles later
   always @(negedge clk) begin
      if (arst_n && res_valid) begin
         got_addr_q.push_back(res_addr);
         got_data_q.push_back(res_data);
         results_seen++;
         if (results_seen - credits_returned > `RES_CREDITS) begin
            $display("More results are outstanding than credits were granted");
            stop_with_failure();
         end else begin
            credit_due_q.push_back(cycle + ($random(seed) & 7));
            -> got_result;
         end
      end
      if (!hold_credits && credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
         void'(credit_due_q.pop_front());
         credits_returned++;
         res_credit = 1'b1;
      end else begin
         res_credit = 1'b0;
      end
   end

   initial begin
      forever begin
         @(got_result);
         while (got_addr_q.size() != 0) begin
            if (exp_addr_q.size() == 0) begin
               $display("A result appeared while no operation was expected");
               stop_with_failure();
            end else begin
               check_value("res_addr", got_addr_q.pop_front(), exp_addr_q.pop_front());
               check_value("res_data", got_data_q.pop_front(), exp_data_q.pop_front());
            end
         end
      end
   end

   always @(negedge clk) begin
      if (dut0.props0.failures != 0) begin
         $display("A bound assertion on the core failed");
         stop_with_failure();
      end
   end

   initial begin
      repeat (RESET_CYCLES + NUM_RUNS * CYCLES_PER_RUN) @(posedge clk);
      $display("Watchdog expired, the core hung before all runs finished");
      stop_with_failure();
   end

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      clk              = 1'b0;
      arst_n           = 1'b0;
      load_en          = 1'b0;
      load_addr        = '0;
      load_data        = '0;
      start            = 1'b0;
      res_credit       = 1'b0;
      hold_credits     = 1'b0;
      seed             = 51;
      cycle            = 0;
      results_seen     = 0;
      credits_returned = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      check_value("busy", busy, 1'b0);
      check_value("done", done, 1'b0);
      check_value("res_valid", res_valid, 1'b0);

      // Random credit return
      load_operands();
      run_program(1'b0);

      // Every credit held back at first
      load_operands();
      run_program(1'b1);

      // Fresh operands so that no state leaks from earlier runs
      load_operands();
      run_program(1'b0);

      check_value("results_seen", results_seen, NUM_RUNS * NUM_OPS);
      $display("Result: PASSED");
      $finish;
   end

endmodule

//--- testbench/cplx_core_properties.sv
`timescale 1ns/1ps
`include "cplx_config.svh"

module cplx_core_properties (
   input logic              clk,
   input logic              arst_n,
   input logic              busy,
   input logic              done,
   input logic              res_valid,
   input logic              res_credit,
   input cplx_pkg::credit_t credits
);
   import cplx_pkg::*;

   // Results seen and not yet given back
   int unreturned;

   int failures = 0;

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         unreturned <= 0;
      end else begin
         unreturned <= unreturned + int'(res_valid) - int'(res_credit);
      end
   end

   //////////////////////////////////////////////////
   // Credits
   //////////////////////////////////////////////////

   credits_in_range: assert property (
      @(posedge clk) disable iff (!arst_n) credits <= credit_t'(`RES_CREDITS)
   ) else begin
      failures++;
      $error("credit count above the initial grant");
   end

   results_bounded: assert property (
      @(posedge clk) disable iff (!arst_n) res_valid |-> unreturned < `RES_CREDITS
   ) else begin
      failures++;
      $error("result sent without a free credit");
   end

   //////////////////////////////////////////////////
   // Reset and halt
   //////////////////////////////////////////////////

   reset_quiet: assert property (
      @(posedge clk) !arst_n |-> !busy && !res_valid && !done
   ) else begin
      failures++;
      $error("outputs active during reset");
   end

   done_single: assert property (
      @(posedge clk) disable iff (!arst_n) done |=> !done
   ) else begin
      failures++;
      $error("done held longer than one cycle");
   end

   halt_idle: assert property (
      @(posedge clk) disable iff (!arst_n) done |=> !busy && !res_valid
   ) else begin
      failures++;
      $error("core still active after done");
   end

endmodule

bind cplx_core cplx_core_properties props0 (
   .clk        (clk),
   .arst_n     (arst_n),
   .busy       (busy),
   .done       (done),
   .res_valid  (res_valid),
   .res_credit (res_credit),
   .credits    (seq0.credits)
);

//--- hw/cplx_core.sv
`timescale 1ns/1ps

module cplx_core (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            load_en,
   input  cplx_pkg::addr_t load_addr,
   input  cplx_pkg::cplx_t load_data,
   input  logic            start,
   output logic            busy,
   output logic            done,
   output logic            res_valid,
   output cplx_pkg::addr_t res_addr,
   output cplx_pkg::cplx_t res_data,
   input  logic            res_credit
);
   import cplx_pkg::*;

   logic        rom_en;
   addr_t       rom_addr;
   inst_t       rom_data;
   addr_t       rd_addr_a;
   addr_t       rd_addr_b;
   cplx_t       rd_data_a;
   cplx_t       rd_data_b;
   logic        ram_wr_en;
   addr_t       ram_wr_addr;
   cplx_t       ram_wr_data;
   logic [1:0]  pend_valid;
   addr_t [1:0] pend_dest;

   cplx_issue_if iss_if ();

   // Writeback owns the RAM write port while busy, load port otherwise
   assign ram_wr_en   = busy ? res_valid : load_en;
   assign ram_wr_addr = busy ? res_addr  : load_addr;
   assign ram_wr_data = busy ? res_data  : load_data;

   inst_rom rom0 (
      .clk      (clk),
      .en       (rom_en),
      .addr     (rom_addr),
      .data_out (rom_data)
   );

   cplx_data_ram ram0 (
      .clk       (clk),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wr_en     (ram_wr_en),
      .wr_addr   (ram_wr_addr),
      .wr_data   (ram_wr_data)
   );

   cplx_seq seq0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start),
      .busy       (busy),
      .done       (done),
      .rom_en     (rom_en),
      .rom_addr   (rom_addr),
      .rom_data   (rom_data),
      .rd_addr_a  (rd_addr_a),
      .rd_addr_b  (rd_addr_b),
      .rd_data_a  (rd_data_a),
      .rd_data_b  (rd_data_b),
      .iss        (iss_if.issuer),
      .pend_valid (pend_valid),
      .pend_dest  (pend_dest),
      .res_credit (res_credit)
   );

   cplx_alu alu0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .iss        (iss_if.exec),
      .res_valid  (res_valid),
      .res_addr   (res_addr),
      .res_data   (res_data),
      .pend_valid (pend_valid),
      .pend_dest  (pend_dest)
   );

endmodule

//--- hw/cplx_seq.sv
`timescale 1ns/1ps
`include "cplx_config.svh"

module cplx_seq (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  start,
   output logic                  busy,
   output logic                  done,
   output logic                  rom_en,
   output cplx_pkg::addr_t       rom_addr,
   input  cplx_pkg::inst_t       rom_data,
   output cplx_pkg::addr_t       rd_addr_a,
   output cplx_pkg::addr_t       rd_addr_b,
   input  cplx_pkg::cplx_t       rd_data_a,
   input  cplx_pkg::cplx_t       rd_data_b,
   cplx_issue_if.issuer          iss,
   input  logic [1:0]            pend_valid,
   input  cplx_pkg::addr_t [1:0] pend_dest,
   input  logic                  res_credit
);
   import cplx_pkg::*;

   seq_state_e state;
   seq_state_e state_nxt;
   addr_t      pc;
   credit_t    credits;
   opcode_e    op;
   addr_t      src1;
   addr_t      src2;
   addr_t      dest;
   logic       hazard;
   logic       hazard_q;
   logic       issue;

   //////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////

   // ROM output holds the word through DECODE and ISSUE
   assign op   = opcode_e'(rom_data[31:29]);
   assign src2 = rom_data[23:16];
   assign src1 = rom_data[15:8];
   assign dest = rom_data[7:0];

   assign rd_addr_a = src1;
   assign rd_addr_b = src2;

   // A source still being produced by the ALU
   always_comb begin
      hazard = 1'b0;
      for (int i = 0; i < 2; i++) begin
         if (pend_valid[i] && (pend_dest[i] == src1 || pend_dest[i] == src2)) begin
            hazard = 1'b1;
         end
      end
   end

   // RAM data seen in ISSUE was read last cycle, so the hazard of that cycle counts
   assign issue = (state == S_ISSUE) && (credits != '0) && !hazard_q;

   //////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (start) begin
               state_nxt = S_FETCH;
            end
         end
         S_FETCH: begin
            state_nxt = S_DECODE;
         end
         S_DECODE: begin
            case (op)
               OP_ADD, OP_SUB, OP_MULT: state_nxt = S_ISSUE;
               default: state_nxt = S_DRAIN;
            endcase
         end
         S_ISSUE: begin
            if (issue) begin
               state_nxt = S_FETCH;
            end
         end
         S_DRAIN: begin
            if (pend_valid == 2'b00) begin
               state_nxt = S_IDLE;
            end
         end
         default: begin
            state_nxt = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= S_IDLE;
         pc       <= '0;
         credits  <= credit_t'(`RES_CREDITS);
         hazard_q <= 1'b0;
      end else begin
         state    <= state_nxt;
         hazard_q <= hazard;
         if (state == S_IDLE && start) begin
            pc <= '0;
         end else if (issue) begin
            pc <= pc + 1'b1;
         end
         // Issue and returned credit in one cycle cancel
         case ({issue, res_credit})
            2'b10: credits <= credits - 1'b1;
            2'b01: credits <= credits + 1'b1;
            default: ;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Outputs
   //////////////////////////////////////////////////

   assign busy     = (state != S_IDLE);
   assign done     = (state == S_DRAIN) && (pend_valid == 2'b00);
   assign rom_en   = (state == S_FETCH);
   assign rom_addr = pc;

   assign iss.valid = issue;
   assign iss.op    = op;
   assign iss.a     = rd_data_a;
   assign iss.b     = rd_data_b;
   assign iss.dest  = dest;

endmodule

//--- hw/cplx_alu.sv
`timescale 1ns/1ps
`include "cplx_config.svh"

module cplx_alu (
   input  logic                  clk,
   input  logic                  arst_n,
   cplx_issue_if.exec            iss,
   output logic                  res_valid,
   output cplx_pkg::addr_t       res_addr,
   output cplx_pkg::cplx_t       res_data,
   output logic [1:0]            pend_valid,
   output cplx_pkg::addr_t [1:0] pend_dest
);
   import cplx_pkg::*;

   localparam int FRAC_BITS = `DATA_WIDTH / 2;

   typedef logic signed [2*`DATA_WIDTH-1:0] prod_t;

   comp_t   ar;
   comp_t   ai;
   comp_t   br;
   comp_t   bi;

   logic    s1_valid;
   opcode_e s1_op;
   addr_t   s1_dest;
   prod_t   p_rr;
   prod_t   p_ii;
   prod_t   p_ri;
   prod_t   p_ir;
   comp_t   s1_re;
   comp_t   s1_im;

   prod_t   mult_re;
   prod_t   mult_im;
   comp_t   out_re;
   comp_t   out_im;

   assign ar = iss.a[2*`DATA_WIDTH-1:`DATA_WIDTH];
   assign ai = iss.a[`DATA_WIDTH-1:0];
   assign br = iss.b[2*`DATA_WIDTH-1:`DATA_WIDTH];
   assign bi = iss.b[`DATA_WIDTH-1:0];

   //////////////////////////////////////////////////
   // Stage valids
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid  <= 1'b0;
         res_valid <= 1'b0;
      end else begin
         s1_valid  <= iss.valid;
         res_valid <= s1_valid;
      end
   end

   //////////////////////////////////////////////////
   // Datapath
   //////////////////////////////////////////////////

   // Q8.8 products back to Q8.8, upper bits wrap away
   assign mult_re = (p_rr - p_ii) >>> FRAC_BITS;
   assign mult_im = (p_ri + p_ir) >>> FRAC_BITS;

   assign out_re = (s1_op == OP_MULT) ? mult_re[`DATA_WIDTH-1:0] : s1_re;
   assign out_im = (s1_op == OP_MULT) ? mult_im[`DATA_WIDTH-1:0] : s1_im;

   always_ff @(posedge clk) begin
      if (iss.valid) begin
         s1_op   <= iss.op;
         s1_dest <= iss.dest;
         p_rr    <= ar * br;
         p_ii    <= ai * bi;
         p_ri    <= ar * bi;
         p_ir    <= ai * br;
         // Sub is src1 minus src2
         s1_re   <= (iss.op == OP_SUB) ? ar - br : ar + br;
         s1_im   <= (iss.op == OP_SUB) ? ai - bi : ai + bi;
      end
      if (s1_valid) begin
         res_addr <= s1_dest;
         res_data <= {out_re, out_im};
      end
   end

   // Scoreboard view, index 1 is the result stage
   assign pend_valid = {res_valid, s1_valid};
   assign pend_dest  = {res_addr, s1_dest};

endmodule

//--- hw/cplx_data_ram.sv
`timescale 1ns/1ps
`include "cplx_config.svh"

module cplx_data_ram (
   input  logic            clk,
   input  cplx_pkg::addr_t rd_addr_a,
   input  cplx_pkg::addr_t rd_addr_b,
   output cplx_pkg::cplx_t rd_data_a,
   output cplx_pkg::cplx_t rd_data_b,
   input  logic            wr_en,
   input  cplx_pkg::addr_t wr_addr,
   input  cplx_pkg::cplx_t wr_data
);
   import cplx_pkg::*;

   cplx_t mem [2**`ADDR_WIDTH];

   // Single write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Two read ports, one cycle latency
   // Same-address read during a write sees the old word
   always_ff @(posedge clk) begin
      rd_data_a <= mem[rd_addr_a];
      rd_data_b <= mem[rd_addr_b];
   end

endmodule

//--- hw/inst_rom.sv
`timescale 1ns/1ps

module inst_rom (
   input  logic            clk,
   input  logic            en,
   input  cplx_pkg::addr_t addr,
   output cplx_pkg::inst_t data_out
);
   import cplx_pkg::*;

   inst_t rom_word;

   //////////////////////////////////////////////////
   // Fixed program
   //////////////////////////////////////////////////

   // 0..2  complex multiplies into 0x80..0x82
   // 3     0x80 + 0x81 into 0x83
   // 4     0x82 - 0x83 into 0x84
   // Zero words halt the sequencer
   always_comb begin
      case (addr)
         8'h00: begin
            rom_word = 32'h8001_0080;
         end
         8'h01: begin
            rom_word = 32'h8003_0281;
         end
         8'h02: begin
            rom_word = 32'h8005_0482;
         end
         8'h03: begin
            rom_word = 32'h2081_8083;
         end
         8'h04: begin
            rom_word = 32'h4083_8284;
         end
         default: begin
            rom_word = '0;
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Registered read
   //////////////////////////////////////////////////

   // Output holds its word while en is low
   always_ff @(posedge clk) begin
      if (en) begin
         data_out <= rom_word;
      end
   end

endmodule

//--- hw/cplx_issue_if.sv
`timescale 1ns/1ps

interface cplx_issue_if;
   import cplx_pkg::*;

   logic    valid;
   opcode_e op;
   cplx_t   a;
   cplx_t   b;
   addr_t   dest;

   modport issuer (
      output valid,
      output op,
      output a,
      output b,
      output dest
   );

   modport exec (
      input valid,
      input op,
      input a,
      input b,
      input dest
   );

endinterface

//--- hw/cplx_pkg.sv
`include "cplx_config.svh"

package cplx_pkg;

   // Instruction word
   // [31:29] opcode, [28:24] reserved, [23:16] src2, [15:8] src1, [7:0] dest
   typedef logic [2*`INST_WIDTH-1:0] inst_t;

   typedef logic [`ADDR_WIDTH-1:0] addr_t;

   // Q8.8 component
   typedef logic signed [`DATA_WIDTH-1:0] comp_t;

   // Real part high, imaginary part low
   typedef logic [2*`DATA_WIDTH-1:0] cplx_t;

   typedef logic [2:0] credit_t;

   typedef enum logic [2:0] {
      OP_HALT = 3'b000,
      OP_ADD  = 3'b001,
      OP_SUB  = 3'b010,
      OP_MULT = 3'b100
   } opcode_e;

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,
      S_DECODE,
      S_ISSUE,
      S_DRAIN
   } seq_state_e;

endpackage

//--- hw/cplx_config.svh
`ifndef CPLX_CONFIG_SVH
`define CPLX_CONFIG_SVH

// Half of one instruction word
// Full instruction is twice this wide
`define INST_WIDTH 16

// One Q8.8 component
`define DATA_WIDTH 16

// ROM and RAM address width
`define ADDR_WIDTH 8

// Result slots the consumer grants after reset
`define RES_CREDITS 4

`endif
